// File: filelist.f
rtl/host_pkg.sv
rtl/periph_pkg.sv
rtl/apb_addr_decoder.sv
rtl/l2_banks.sv
rtl/periph_regs.sv
rtl/edge_propagator_rx.sv
rtl/host_domain.sv
sim/tb_host_domain.sv

// File: run.sh
#!/bin/sh
# Build and run the host domain testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_host_domain \
  -f filelist.f -o tb_host_domain_sim || { echo "Build failed"; exit 1; }

out=$(./obj_dir/tb_host_domain_sim)
echo "$out"
echo "$out" | grep -q "^TESTS PASSED$" && exit 0 || exit 1

// File: sim/tb_host_domain.sv
// ---------------------------------------
// Self-checking testbench for the host domain
// APB table, random L2 traffic, cluster events
// ---------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_host_domain
  import host_pkg::*;
();

  localparam int unsigned NbL2Banks   = 4;
  localparam int unsigned L2BankWords = 64;
  localparam int unsigned NumGpio     = 16;
  localparam int unsigned L2Words     = NbL2Banks * L2BankWords;
  localparam int unsigned NumRandOps  = 200;
  localparam int unsigned NumEvents   = 260;

  localparam logic        OpWr = 1'b1;
  localparam logic        OpRd = 1'b0;
  localparam logic [31:0] GpioMask = (32'h1 << NumGpio) - 32'h1;
  localparam logic [15:0] GpioInVal = 16'h5A3C;

  // Peripheral byte offsets
  localparam logic [31:0] OffsGpioOut = 32'h00;
  localparam logic [31:0] OffsGpioDir = 32'h04;
  localparam logic [31:0] OffsGpioIn  = 32'h08;
  localparam logic [31:0] OffsEvtPend = 32'h0C;
  localparam logic [31:0] OffsEvtMask = 32'h10;
  localparam logic [31:0] OffsEvtCnt  = 32'h14;

  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
  } entry_t;

  logic                clk_i;
  logic                arst_n_i;
  logic [31:0]         paddr_i;
  logic                psel_i;
  logic                penable_i;
  logic                pwrite_i;
  logic [31:0]         pwdata_i;
  logic [31:0]         prdata_o;
  logic                pready_o;
  logic                pslverr_o;
  logic [NumGpio-1:0]  gpio_i;
  logic [NumGpio-1:0]  gpio_o;
  logic [NumGpio-1:0]  gpio_oe_o;
  logic                irq_o;
  logic                dma_pe_evt_valid_i;
  logic                dma_pe_evt_ack_o;

  entry_t      tbl_q [$];
  logic [31:0] l2_model [int unsigned];
  int unsigned written_q [$];
  bit          table_built;
  int          err_count;
  int          check_count;

  host_domain #(
    .NB_L2_BANKS   ( NbL2Banks   ),
    .L2_BANK_WORDS ( L2BankWords ),
    .NUM_GPIO      ( NumGpio     )
  ) DUT (
    .clk_i              ( clk_i              ),
    .arst_n_i           ( arst_n_i           ),
    .paddr_i            ( paddr_i            ),
    .psel_i             ( psel_i             ),
    .penable_i          ( penable_i          ),
    .pwrite_i           ( pwrite_i           ),
    .pwdata_i           ( pwdata_i           ),
    .prdata_o           ( prdata_o           ),
    .pready_o           ( pready_o           ),
    .pslverr_o          ( pslverr_o          ),
    .gpio_i             ( gpio_i             ),
    .gpio_o             ( gpio_o             ),
    .gpio_oe_o          ( gpio_oe_o          ),
    .irq_o              ( irq_o              ),
    .dma_pe_evt_valid_i ( dma_pe_evt_valid_i ),
    .dma_pe_evt_ack_o   ( dma_pe_evt_ack_o   )
  );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] l2_pattern(input int unsigned idx);
    return 32'hC0DE_0000 ^ (32'(idx) * 32'h0001_1111);
  endfunction

  function automatic bit is_l2(input logic [31:0] addr);
    return (addr - L2BaseAddr) < L2WinSize;
  endfunction

  // L2 word index, wrapped to the physical size
  function automatic int unsigned l2_word(input logic [31:0] addr);
    return 32'((addr - L2BaseAddr) >> 2) % L2Words;
  endfunction

  function automatic void add_entry(input logic wr, input logic [31:0] addr,
                                    input logic [31:0] wdata, input logic [31:0] exp_rdata,
                                    input logic exp_err);
    entry_t e;
    e.wr        = wr;
    e.addr      = addr;
    e.wdata     = wdata;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    tbl_q.push_back(e);
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      err_count++;
      $display("** Error @ %0d ns: %s expected 0x%08h, got 0x%08h", $time, what, exp, got);
    end
  endtask

  // One APB transfer, response sampled mid-cycle
  task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk_i);
    #1;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge clk_i);
    #1;
    penable_i = 1'b1;
    @(negedge clk_i);
    while (!pready_o) @(negedge clk_i);
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk_i);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(OpWr, addr, wdata, rdata, err);
    check_value($sformatf("pslverr of write 0x%08h", addr), {31'b0, err}, 32'h0);
  endtask

  task automatic apb_read_check(input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(OpRd, addr, 32'h0, rdata, err);
    check_value($sformatf("pslverr of read 0x%08h", addr), {31'b0, err}, 32'h0);
    check_value($sformatf("read 0x%08h", addr), rdata, exp);
  endtask

  function automatic void build_table();
    logic [31:0] wrap_addr;
    wrap_addr = L2BaseAddr + 32'(L2Words * 4) + 32'h8;
    // Eight consecutive words span every bank twice
    for (int unsigned i = 0; i < 8; i++) begin
      add_entry(OpWr, L2BaseAddr + 32'(i * 4), l2_pattern(i), 32'h0, 1'b0);
    end
    for (int unsigned i = 0; i < 8; i++) begin
      add_entry(OpRd, L2BaseAddr + 32'(i * 4), 32'h0, l2_pattern(i), 1'b0);
    end
    add_entry(OpWr, wrap_addr, 32'hDEAD_BEEF, 32'h0, 1'b0);
    add_entry(OpRd, L2BaseAddr + 32'h8, 32'h0, 32'hDEAD_BEEF, 1'b0);
    add_entry(OpRd, wrap_addr, 32'h0, 32'hDEAD_BEEF, 1'b0);
    // Outside both windows
    add_entry(OpWr, 32'h3000_0000, 32'h1111_1111, 32'h0, 1'b1);
    add_entry(OpRd, 32'h3000_0000, 32'h0, 32'h0, 1'b1);
    // Would alias word 1 if it reached the L2
    add_entry(OpWr, L2BaseAddr - 32'(L2Words * 4) + 32'h4, 32'h2222_2222, 32'h0, 1'b1);
    add_entry(OpRd, PeriphBaseAddr + 32'h1000, 32'h0, 32'h0, 1'b1);
    add_entry(OpRd, L2BaseAddr, 32'h0, l2_pattern(0), 1'b0);
    add_entry(OpRd, L2BaseAddr + 32'h4, 32'h0, l2_pattern(1), 1'b0);
    // GPIO and unknown peripheral offsets
    add_entry(OpWr, PeriphBaseAddr + OffsGpioOut, 32'hFFFF_1234, 32'h0, 1'b0);
    add_entry(OpRd, PeriphBaseAddr + OffsGpioOut, 32'h0, 32'hFFFF_1234 & GpioMask, 1'b0);
    add_entry(OpWr, PeriphBaseAddr + OffsGpioDir, 32'hABCD_00F0, 32'h0, 1'b0);
    add_entry(OpRd, PeriphBaseAddr + OffsGpioDir, 32'h0, 32'hABCD_00F0 & GpioMask, 1'b0);
    add_entry(OpRd, PeriphBaseAddr + OffsGpioIn, 32'h0, 32'(GpioInVal), 1'b0);
    add_entry(OpRd, PeriphBaseAddr + OffsEvtPend, 32'h0, 32'h0, 1'b0);
    add_entry(OpRd, PeriphBaseAddr + OffsEvtCnt, 32'h0, 32'h0, 1'b0);
    add_entry(OpWr, PeriphBaseAddr + 32'h20, 32'hFFFF_FFFF, 32'h0, 1'b0);
    add_entry(OpRd, PeriphBaseAddr + 32'h20, 32'h0, 32'h0, 1'b0);
  endfunction

  task automatic run_table();
    logic [31:0] rdata;
    logic        err;
    int unsigned w;
    foreach (tbl_q[i]) begin
      apb_xfer(tbl_q[i].wr, tbl_q[i].addr, tbl_q[i].wdata, rdata, err);
      check_value($sformatf("pslverr of entry %0d", i), {31'b0, err}, {31'b0, tbl_q[i].exp_err});
      if (!tbl_q[i].wr) begin
        check_value($sformatf("prdata of entry %0d", i), rdata, tbl_q[i].exp_rdata);
      end else if (!tbl_q[i].exp_err && is_l2(tbl_q[i].addr)) begin
        w = l2_word(tbl_q[i].addr);
        if (!l2_model.exists(w)) begin
          written_q.push_back(w);
        end
        l2_model[w] = tbl_q[i].wdata;
      end
    end
  endtask

  task automatic random_l2_stream();
    int unsigned w;
    logic [31:0] data;
    repeat (NumRandOps) begin
      if (($urandom_range(0, 1) == 0) && (written_q.size() > 0)) begin
        w = written_q[$urandom_range(0, written_q.size() - 1)];
        apb_read_check(L2BaseAddr + 32'(w * 4), l2_model[w]);
      end else begin
        w    = $urandom_range(0, L2Words - 1);
        data = $urandom();
        apb_write(L2BaseAddr + 32'(w * 4), data);
        if (!l2_model.exists(w)) begin
          written_q.push_back(w);
        end
        l2_model[w] = data;
      end
    end
  endtask

  // Cluster side of the four-phase handshake
  task automatic send_cluster_event();
    @(posedge clk_i);
    #1;
    dma_pe_evt_valid_i = 1'b1;
    do @(negedge clk_i); while (!dma_pe_evt_ack_o);
    @(posedge clk_i);
    #1;
    dma_pe_evt_valid_i = 1'b0;
    do @(negedge clk_i); while (dma_pe_evt_ack_o);
  endtask

  initial begin : watchdog
    wait (table_built);
    repeat ((tbl_q.size() + NumRandOps) * 20 + NumEvents * 20 + 100) @(posedge clk_i);
    $display("Simulation timed out before all tests completed");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main
    clk_i              = 1'b0;
    arst_n_i           = 1'b0;
    paddr_i            = '0;
    psel_i             = 1'b0;
    penable_i          = 1'b0;
    pwrite_i           = 1'b0;
    pwdata_i           = '0;
    gpio_i             = '0;
    dma_pe_evt_valid_i = 1'b0;
    err_count          = 0;
    check_count        = 0;
    void'($urandom(80486));
    build_table();
    table_built = 1'b1;

    @(negedge clk_i);
    check_value("pready_o in reset", {31'b0, pready_o}, 32'h0);
    check_value("pslverr_o in reset", {31'b0, pslverr_o}, 32'h0);
    check_value("irq_o in reset", {31'b0, irq_o}, 32'h0);
    check_value("ack in reset", {31'b0, dma_pe_evt_ack_o}, 32'h0);
    check_value("gpio_o in reset", 32'(gpio_o), 32'h0);
    check_value("gpio_oe_o in reset", 32'(gpio_oe_o), 32'h0);
    repeat (3) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    gpio_i   = GpioInVal;
    // Let the input synchronizer settle
    repeat (4) @(posedge clk_i);

    run_table();
    @(negedge clk_i);
    check_value("gpio_o", 32'(gpio_o), 32'hFFFF_1234 & GpioMask);
    check_value("gpio_oe_o", 32'(gpio_oe_o), 32'hABCD_00F0 & GpioMask);

    random_l2_stream();

    repeat (NumEvents) send_cluster_event();
    apb_read_check(PeriphBaseAddr + OffsEvtCnt, 32'(NumEvents % 256));
    apb_read_check(PeriphBaseAddr + OffsEvtPend, 32'h1);
    @(negedge clk_i);
    check_value("irq_o while masked", {31'b0, irq_o}, 32'h0);
    apb_write(PeriphBaseAddr + OffsEvtMask, 32'h1);
    @(negedge clk_i);
    check_value("irq_o after unmask", {31'b0, irq_o}, 32'h1);
    apb_write(PeriphBaseAddr + OffsEvtPend, 32'h1);
    @(negedge clk_i);
    check_value("irq_o after clear", {31'b0, irq_o}, 32'h0);
    apb_read_check(PeriphBaseAddr + OffsEvtPend, 32'h0);

    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/host_domain.sv
// ---------------------------------------
// Host domain top with L2, GPIO and events
// ---------------------------------------

`timescale 1ns/10ps
`default_nettype none

module host_domain
  import host_pkg::*;
#(
  parameter int unsigned NB_L2_BANKS   = 4,
  parameter int unsigned L2_BANK_WORDS = 64,
  parameter int unsigned NUM_GPIO      = 16
) (
  input  wire logic                    clk_i,
  input  wire logic                    arst_n_i,
  // Host APB
  input  wire logic [ApbAddrWidth-1:0] paddr_i,
  input  wire logic                    psel_i,
  input  wire logic                    penable_i,
  input  wire logic                    pwrite_i,
  input  wire logic [ApbDataWidth-1:0] pwdata_i,
  output logic      [ApbDataWidth-1:0] prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  // GPIO and interrupt
  input  wire logic [NUM_GPIO-1:0]     gpio_i,
  output logic      [NUM_GPIO-1:0]     gpio_o,
  output logic      [NUM_GPIO-1:0]     gpio_oe_o,
  output logic                         irq_o,
  // Cluster DMA event
  input  wire logic                    dma_pe_evt_valid_i,
  output logic                         dma_pe_evt_ack_o
);

  logic                    l2_psel;
  logic                    periph_psel;
  logic                    penable;
  logic                    pwrite;
  logic [ApbAddrWidth-1:0] offs;
  logic [ApbDataWidth-1:0] pwdata;
  logic [ApbDataWidth-1:0] l2_prdata;
  logic                    l2_pready;
  logic [ApbDataWidth-1:0] periph_prdata;
  logic                    periph_pready;
  logic                    dma_pe_evt;

  apb_addr_decoder i_apb_addr_decoder (
    .paddr_i         ( paddr_i       ),
    .psel_i          ( psel_i        ),
    .penable_i       ( penable_i     ),
    .pwrite_i        ( pwrite_i      ),
    .pwdata_i        ( pwdata_i      ),
    .l2_psel_o       ( l2_psel       ),
    .periph_psel_o   ( periph_psel   ),
    .penable_o       ( penable       ),
    .pwrite_o        ( pwrite        ),
    .offs_o          ( offs          ),
    .pwdata_o        ( pwdata        ),
    .l2_prdata_i     ( l2_prdata     ),
    .l2_pready_i     ( l2_pready     ),
    .periph_prdata_i ( periph_prdata ),
    .periph_pready_i ( periph_pready ),
    .prdata_o        ( prdata_o      ),
    .pready_o        ( pready_o      ),
    .pslverr_o       ( pslverr_o     )
  );

  l2_banks #(
    .NB_L2_BANKS   ( NB_L2_BANKS   ),
    .L2_BANK_WORDS ( L2_BANK_WORDS )
  ) i_l2_banks (
    .clk_i     ( clk_i     ),
    .arst_n_i  ( arst_n_i  ),
    .psel_i    ( l2_psel   ),
    .penable_i ( penable   ),
    .pwrite_i  ( pwrite    ),
    .offs_i    ( offs      ),
    .pwdata_i  ( pwdata    ),
    .prdata_o  ( l2_prdata ),
    .pready_o  ( l2_pready )
  );

  periph_regs #(
    .NUM_GPIO ( NUM_GPIO )
  ) i_periph_regs (
    .clk_i       ( clk_i         ),
    .arst_n_i    ( arst_n_i      ),
    .psel_i      ( periph_psel   ),
    .penable_i   ( penable       ),
    .pwrite_i    ( pwrite        ),
    .offs_i      ( offs          ),
    .pwdata_i    ( pwdata        ),
    .gpio_i      ( gpio_i        ),
    .evt_pulse_i ( dma_pe_evt    ),
    .prdata_o    ( periph_prdata ),
    .pready_o    ( periph_pready ),
    .gpio_o      ( gpio_o        ),
    .gpio_oe_o   ( gpio_oe_o     ),
    .irq_o       ( irq_o         )
  );

  edge_propagator_rx i_ep_dma_pe_evt (
    .clk_i    ( clk_i              ),
    .arst_n_i ( arst_n_i           ),
    .valid_i  ( dma_pe_evt_valid_i ),
    .valid_o  ( dma_pe_evt         ),
    .ack_o    ( dma_pe_evt_ack_o   )
  );

endmodule

`default_nettype wire

// File: rtl/edge_propagator_rx.sv
// ---------------------------------------
// Receiver for a four-phase event handshake
// One pulse per cluster event
// ---------------------------------------

`timescale 1ns/10ps
`default_nettype none

module edge_propagator_rx (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  input  wire logic valid_i,
  output logic      valid_o,
  output logic      ack_o
);

  logic [1:0] sync_q;
  logic       ack_q;

  // sync_q[1] is the synchronized valid, ack_q trails it by one clock
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
      ack_q  <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], valid_i};
      ack_q  <= sync_q[1];
    end
  end

  // Rising edge of the synchronized valid
  assign valid_o = sync_q[1] && !ack_q;
  assign ack_o   = ack_q;

  a_single_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o |=> !valid_o);

endmodule

`default_nettype wire

// File: rtl/periph_regs.sv
// ---------------------------------------
// GPIO registers and event unit on APB
// ---------------------------------------

`timescale 1ns/10ps
`default_nettype none

module periph_regs
  import host_pkg::*;
  import periph_pkg::*;
#(
  // At most 32
  parameter int unsigned NUM_GPIO = 16
) (
  input  wire logic                    clk_i,
  input  wire logic                    arst_n_i,
  input  wire logic                    psel_i,
  input  wire logic                    penable_i,
  input  wire logic                    pwrite_i,
  input  wire logic [ApbAddrWidth-1:0] offs_i,
  input  wire logic [ApbDataWidth-1:0] pwdata_i,
  input  wire logic [NUM_GPIO-1:0]     gpio_i,
  input  wire logic                    evt_pulse_i,
  output logic      [ApbDataWidth-1:0] prdata_o,
  output logic                         pready_o,
  output logic      [NUM_GPIO-1:0]     gpio_o,
  output logic      [NUM_GPIO-1:0]     gpio_oe_o,
  output logic                         irq_o
);

  logic                in_range;
  reg_offset_e         reg_idx;
  logic                wr_en;
  logic [NUM_GPIO-1:0] gpio_out_q;
  logic [NUM_GPIO-1:0] gpio_dir_q;
  logic [NUM_GPIO-1:0] gpio_meta_q;
  logic [NUM_GPIO-1:0] gpio_in_q;
  logic                pend_q;
  logic                mask_q;
  logic [7:0]          count_q;

  // Only the first 16 words of the window hold registers
  assign in_range = (offs_i[ApbAddrWidth-1:6] == '0);
  assign reg_idx  = reg_offset_e'(offs_i[5:2]);
  assign wr_en    = psel_i && penable_i && pwrite_i && in_range;
  assign pready_o = psel_i && penable_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_out_q <= '0;
      gpio_dir_q <= '0;
      mask_q     <= 1'b0;
    end else if (wr_en) begin
      case (reg_idx)
        REG_GPIO_OUT: gpio_out_q <= pwdata_i[NUM_GPIO-1:0];
        REG_GPIO_DIR: gpio_dir_q <= pwdata_i[NUM_GPIO-1:0];
        REG_EVT_MASK: mask_q <= pwdata_i[0];
        default: ;
      endcase
    end
  end

  // Two-flop input synchronizer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_meta_q <= '0;
      gpio_in_q   <= '0;
    end else begin
      gpio_meta_q <= gpio_i;
      gpio_in_q   <= gpio_meta_q;
    end
  end

  // Event unit; a new event beats a clear in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q  <= 1'b0;
      count_q <= '0;
    end else begin
      if (evt_pulse_i) begin
        pend_q  <= 1'b1;
        count_q <= count_q + 8'd1;
      end else if (wr_en && (reg_idx == REG_EVT_PENDING) && pwdata_i[0]) begin
        pend_q <= 1'b0;
      end
    end
  end

  // Read mux
  always_comb begin
    prdata_o = '0;
    if (in_range) begin
      case (reg_idx)
        REG_GPIO_OUT:    prdata_o = ApbDataWidth'(gpio_out_q);
        REG_GPIO_DIR:    prdata_o = ApbDataWidth'(gpio_dir_q);
        REG_GPIO_IN:     prdata_o = ApbDataWidth'(gpio_in_q);
        REG_EVT_PENDING: prdata_o = ApbDataWidth'(pend_q);
        REG_EVT_MASK:    prdata_o = ApbDataWidth'(mask_q);
        REG_EVT_COUNT:   prdata_o = ApbDataWidth'(count_q);
        default:         prdata_o = '0;
      endcase
    end
  end

  assign gpio_o    = gpio_out_q;
  assign gpio_oe_o = gpio_dir_q;
  assign irq_o     = pend_q && mask_q;

endmodule

`default_nettype wire

// File: rtl/l2_banks.sv
// ---------------------------------------
// Word-interleaved L2 scratchpad on APB
// Reads take one wait state
// ---------------------------------------

`timescale 1ns/10ps
`default_nettype none

module l2_banks
  import host_pkg::*;
  import periph_pkg::*;
#(
  parameter int unsigned NB_L2_BANKS   = 4,
  parameter int unsigned L2_BANK_WORDS = 64
) (
  input  wire logic                    clk_i,
  input  wire logic                    arst_n_i,
  input  wire logic                    psel_i,
  input  wire logic                    penable_i,
  input  wire logic                    pwrite_i,
  input  wire logic [ApbAddrWidth-1:0] offs_i,
  input  wire logic [ApbDataWidth-1:0] pwdata_i,
  output logic      [ApbDataWidth-1:0] prdata_o,
  output logic                         pready_o
);

  // Both counts are powers of two, with at least two banks
  localparam int unsigned BankBits = $clog2(NB_L2_BANKS);
  localparam int unsigned WordBits = $clog2(L2_BANK_WORDS);

  logic [BankBits-1:0]     bank_sel;
  logic [WordBits-1:0]     bank_word;
  logic                    wr_en;
  logic                    rd_start;
  logic [ApbDataWidth-1:0] bank_rdata [NB_L2_BANKS];
  logic [ApbDataWidth-1:0] rdata_q;
  l2_state_e               state_q;
  l2_state_e               state_d;

  // Low word bits pick the bank, so consecutive words hit different banks.
  // Bits above the L2 size are dropped and the address wraps.
  assign bank_sel  = offs_i[2 +: BankBits];
  assign bank_word = offs_i[2 + BankBits +: WordBits];

  assign wr_en    = psel_i && penable_i && pwrite_i;
  assign rd_start = psel_i && penable_i && !pwrite_i && (state_q == L2_IDLE);

  for (genvar b = 0; b < NB_L2_BANKS; b++) begin : gen_bank
    logic [ApbDataWidth-1:0] mem_q [L2_BANK_WORDS];

    always_ff @(posedge clk_i) begin
      if (wr_en && (bank_sel == BankBits'(b))) begin
        mem_q[bank_word] <= pwdata_i;
      end
    end

    assign bank_rdata[b] = mem_q[bank_word];
  end

  // Read FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      L2_IDLE: begin
        if (rd_start) begin
          state_d = L2_RDWAIT;
        end
      end
      default: state_d = L2_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= L2_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Selected bank output captured in the first access cycle
  always_ff @(posedge clk_i) begin
    if (rd_start) begin
      rdata_q <= bank_rdata[bank_sel];
    end
  end

  assign prdata_o = rdata_q;
  assign pready_o = psel_i && penable_i && (pwrite_i || (state_q == L2_RDWAIT));

  // Requester holds the transfer during the wait state
  a_offs_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (state_q == L2_RDWAIT) |-> (psel_i && penable_i && $stable(offs_i)));

endmodule

`default_nettype wire

// File: rtl/apb_addr_decoder.sv
// ---------------------------------------
// APB decoder for L2 and peripherals
// Answers unmapped addresses with an error
// ---------------------------------------

`timescale 1ns/10ps
`default_nettype none

module apb_addr_decoder
  import host_pkg::*;
(
  input  wire logic [ApbAddrWidth-1:0] paddr_i,
  input  wire logic                    psel_i,
  input  wire logic                    penable_i,
  input  wire logic                    pwrite_i,
  input  wire logic [ApbDataWidth-1:0] pwdata_i,
  output logic                         l2_psel_o,
  output logic                         periph_psel_o,
  output logic                         penable_o,
  output logic                         pwrite_o,
  output logic      [ApbAddrWidth-1:0] offs_o,
  output logic      [ApbDataWidth-1:0] pwdata_o,
  input  wire logic [ApbDataWidth-1:0] l2_prdata_i,
  input  wire logic                    l2_pready_i,
  input  wire logic [ApbDataWidth-1:0] periph_prdata_i,
  input  wire logic                    periph_pready_i,
  output logic      [ApbDataWidth-1:0] prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o
);

  logic [ApbAddrWidth-1:0] l2_offs;
  logic [ApbAddrWidth-1:0] periph_offs;
  target_e                 tgt;

  // Unsigned difference also rejects addresses below the base
  assign l2_offs     = paddr_i - L2BaseAddr;
  assign periph_offs = paddr_i - PeriphBaseAddr;

  always_comb begin
    if (l2_offs < L2WinSize) begin
      tgt = TGT_L2;
    end else if (periph_offs < PeriphWinSize) begin
      tgt = TGT_PERIPH;
    end else begin
      tgt = TGT_NONE;
    end
  end

  // Request side
  assign l2_psel_o     = psel_i && (tgt == TGT_L2);
  assign periph_psel_o = psel_i && (tgt == TGT_PERIPH);
  assign penable_o     = penable_i;
  assign pwrite_o      = pwrite_i;
  assign pwdata_o      = pwdata_i;
  assign offs_o        = (tgt == TGT_PERIPH) ? periph_offs : l2_offs;

  // Response side
  always_comb begin
    prdata_o  = '0;
    pready_o  = 1'b0;
    pslverr_o = 1'b0;
    case (tgt)
      TGT_L2: begin
        prdata_o = l2_prdata_i;
        pready_o = l2_pready_i;
      end
      TGT_PERIPH: begin
        prdata_o = periph_prdata_i;
        pready_o = periph_pready_i;
      end
      default: begin
        // Unmapped, error in the first access cycle
        pready_o  = psel_i && penable_i;
        pslverr_o = psel_i && penable_i;
      end
    endcase
  end

  // Checked at the start of every access phase
  a_sel_onehot: assert property (@(posedge penable_i) $onehot0({l2_psel_o, periph_psel_o}));

endmodule

`default_nettype wire

// File: rtl/periph_pkg.sv
// ---------------------------------------
// Peripheral register map and L2 states
// ---------------------------------------

`default_nettype none

package periph_pkg;

  // Word index of each peripheral register
  // Byte offset in the window is the index times 4
  typedef enum logic [3:0] {
    REG_GPIO_OUT    = 4'h0,  // 0x00
    REG_GPIO_DIR    = 4'h1,  // 0x04
    REG_GPIO_IN     = 4'h2,  // 0x08
    REG_EVT_PENDING = 4'h3,  // 0x0C
    REG_EVT_MASK    = 4'h4,  // 0x10
    REG_EVT_COUNT   = 4'h5   // 0x14
  } reg_offset_e;

  // L2 read path states
  typedef enum logic {
    L2_IDLE   = 1'b0,
    L2_RDWAIT = 1'b1
  } l2_state_e;

endpackage

`default_nettype wire

// File: rtl/host_pkg.sv
// ---------------------------------------
// Host domain address map and bus widths
// ---------------------------------------

`default_nettype none

package host_pkg;

  // APB bus widths
  localparam int unsigned ApbAddrWidth = 32;
  localparam int unsigned ApbDataWidth = 32;

  // L2 scratchpad window
  // The physical L2 is smaller than the window, so accesses wrap inside it
  localparam logic [ApbAddrWidth-1:0] L2BaseAddr = 32'h1C00_0000;
  localparam logic [ApbAddrWidth-1:0] L2WinSize  = 32'h0010_0000;

  // Peripheral block window, 4 KiB
  localparam logic [ApbAddrWidth-1:0] PeriphBaseAddr = 32'h1A10_0000;
  localparam logic [ApbAddrWidth-1:0] PeriphWinSize  = 32'h0000_1000;

  // Decode targets of the host APB
  typedef enum logic [1:0] {
    TGT_L2     = 2'd0,
    TGT_PERIPH = 2'd1,
    TGT_NONE   = 2'd2
  } target_e;

endpackage

`default_nettype wire
